// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := cache_tb
FILELIST  := dm_cache.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Checks failed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dm_cache.f
+incdir+hdl
hdl/dm_cache_pkg.sv
hdl/cache_ctrl.sv
hdl/main_memory.sv
hdl/cache_subsystem.sv
tb/cache_tb.sv

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps
`include "dm_cache_consts.svh"

module cache_ctrl (
    input  logic                      clk,
    input  logic                      resetn,

    // Requester side
    input  dm_cache_pkg::block_addr_t cblock_addr,
    input  dm_cache_pkg::word_t       cwdata,
    input  dm_cache_pkg::strb_t       cwstrb,
    input  logic                      cvalid,
    output dm_cache_pkg::word_t       crdata,
    output logic                      cready,

    // Main memory side
    output dm_cache_pkg::block_addr_t maddr,
    output dm_cache_pkg::word_t       mwdata,
    output dm_cache_pkg::strb_t       mwstrb,
    output logic                      mvalid,
    input  dm_cache_pkg::word_t       mrdata,
    input  logic                      mready
);

    localparam int LINES = 1 << `DC_INDEX_BITS;

    // ############################################################
    // Line storage
    // ############################################################

    logic [LINES-1:0]    valid_bits;                // One valid flag per line
    dm_cache_pkg::tag_t  tag_mem  [0:LINES-1];
    dm_cache_pkg::word_t data_mem [0:LINES-1];

    // Registered copy of the addressed line taken at acceptance
    logic                line_valid;
    dm_cache_pkg::tag_t  line_tag;
    dm_cache_pkg::word_t line_data;

    dm_cache_pkg::index_t       req_index;
    dm_cache_pkg::tag_t         req_tag;
    dm_cache_pkg::cache_state_t state;

    // The requester holds its address until cready, so it can be split directly
    assign req_index = cblock_addr[`DC_INDEX_BITS-1:0];
    assign req_tag   = cblock_addr[$bits(dm_cache_pkg::block_addr_t)-1:`DC_INDEX_BITS];

    assign crdata = line_data;                      // Hit, refill and full write all land here

    // ############################################################
    // Request state machine
    // ############################################################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= dm_cache_pkg::IDLE;
            cready     <= 1'b0;
            mvalid     <= 1'b0;
            mwstrb     <= '0;
            line_valid <= 1'b0;
            // A zero is shifted in each reset cycle, so 8 cycles clear every line
            valid_bits <= {valid_bits[LINES-2:0], 1'b0};
        end else begin
            unique case (state)
                dm_cache_pkg::IDLE: begin
                    cready <= 1'b0;                 // Ends the completion pulse
                    if (cvalid && !cready) begin
                        maddr <= cblock_addr;
                        if (|cwstrb) begin
                            mwdata <= cwdata;
                            mwstrb <= cwstrb;
                            mvalid <= 1'b1;         // Writes always go to memory first
                            state  <= dm_cache_pkg::WRITE_THROUGH;
                        end else begin
                            mwstrb     <= '0;
                            line_valid <= valid_bits[req_index];
                            line_tag   <= tag_mem[req_index];
                            line_data  <= data_mem[req_index];
                            state      <= dm_cache_pkg::LOOKUP;
                        end
                    end
                end

                dm_cache_pkg::LOOKUP: begin
                    if (line_valid && line_tag == req_tag) begin
                        cready <= 1'b1;             // On a hit the line copy is already on crdata
                        state  <= dm_cache_pkg::IDLE;
                    end else begin
                        mvalid <= 1'b1;             // A miss fetches the word from memory
                        state  <= dm_cache_pkg::REFILL_WAIT;
                    end
                end

                dm_cache_pkg::WRITE_THROUGH: begin
                    if (mready) begin
                        mvalid <= 1'b0;
                        mwstrb <= '0;
                        if (&mwstrb) begin
                            // A full word can go straight into the line
                            valid_bits[req_index] <= 1'b1;
                            tag_mem[req_index]    <= req_tag;
                            data_mem[req_index]   <= mwdata;
                            line_data             <= mwdata;
                            cready                <= 1'b1;
                            state                 <= dm_cache_pkg::IDLE;
                        end else begin
                            state <= dm_cache_pkg::REREAD_ISSUE;
                        end
                    end
                end

                dm_cache_pkg::REREAD_ISSUE: begin
                    // mvalid was low for one cycle, so memory sees a fresh request
                    mvalid <= 1'b1;
                    state  <= dm_cache_pkg::REFILL_WAIT;
                end

                dm_cache_pkg::REFILL_WAIT: begin
                    if (mready) begin
                        mvalid                <= 1'b0;
                        valid_bits[req_index] <= 1'b1;
                        tag_mem[req_index]    <= req_tag;
                        data_mem[req_index]   <= mrdata;
                        line_data             <= mrdata;
                        cready                <= 1'b1;
                        state                 <= dm_cache_pkg::IDLE;
                    end
                end

                default: begin
                    state <= dm_cache_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem (
    input  logic                      clk,
    input  logic                      resetn,
    input  dm_cache_pkg::block_addr_t cblock_addr,
    input  dm_cache_pkg::word_t       cwdata,
    input  dm_cache_pkg::strb_t       cwstrb,
    input  logic                      cvalid,
    output dm_cache_pkg::word_t       crdata,
    output logic                      cready
);

    // ############################################################
    // Cache to memory link
    // ############################################################

    dm_cache_pkg::block_addr_t maddr;
    dm_cache_pkg::word_t       mwdata;
    dm_cache_pkg::strb_t       mwstrb;
    logic                      mvalid;
    dm_cache_pkg::word_t       mrdata;
    logic                      mready;

    cache_ctrl u_cache (
        .clk         (clk),
        .resetn      (resetn),
        .cblock_addr (cblock_addr),
        .cwdata      (cwdata),
        .cwstrb      (cwstrb),
        .cvalid      (cvalid),
        .crdata      (crdata),
        .cready      (cready),
        .maddr       (maddr),
        .mwdata      (mwdata),
        .mwstrb      (mwstrb),
        .mvalid      (mvalid),
        .mrdata      (mrdata),
        .mready      (mready)
    );

    main_memory u_memory (
        .clk    (clk),
        .resetn (resetn),
        .maddr  (maddr),
        .mwdata (mwdata),
        .mwstrb (mwstrb),
        .mvalid (mvalid),
        .mrdata (mrdata),
        .mready (mready)
    );

endmodule

// File: hdl/dm_cache_consts.svh
`ifndef DM_CACHE_CONSTS_SVH
`define DM_CACHE_CONSTS_SVH

// ############################################################
// Bus widths
// ############################################################

`define DC_ADDR_BITS       32     // Byte address width seen by the core
`define DC_WORD_BITS       32     // One data word per cache line
`define DC_STRB_BITS       4      // Byte lanes in a word

// ############################################################
// Cache and memory geometry
// ############################################################

`define DC_INDEX_BITS      3      // Gives 8 direct-mapped lines
`define DC_MEM_DEPTH_BITS  8      // Main memory keeps 256 words
`define DC_MEM_LATENCY     3      // Wait cycles before memory answers

`endif

// File: hdl/dm_cache_pkg.sv
`include "dm_cache_consts.svh"

package dm_cache_pkg;

    // Word address without the two byte offset bits
    typedef logic [`DC_ADDR_BITS-$clog2(`DC_STRB_BITS)-1:0] block_addr_t;
    typedef logic [`DC_WORD_BITS-1:0]                        word_t;
    typedef logic [`DC_STRB_BITS-1:0]                        strb_t;  // All zero marks a read
    typedef logic [`DC_INDEX_BITS-1:0]                       index_t;
    typedef logic [$bits(block_addr_t)-`DC_INDEX_BITS-1:0]   tag_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_THROUGH,
        REREAD_ISSUE,
        REFILL_WAIT
    } cache_state_t;

endpackage

// File: hdl/main_memory.sv
`timescale 1ns/1ps
`include "dm_cache_consts.svh"

module main_memory (
    input  logic                      clk,
    input  logic                      resetn,
    input  dm_cache_pkg::block_addr_t maddr,
    input  dm_cache_pkg::word_t       mwdata,
    input  dm_cache_pkg::strb_t       mwstrb,
    input  logic                      mvalid,
    output dm_cache_pkg::word_t       mrdata,
    output logic                      mready
);

    localparam int WORDS    = 1 << `DC_MEM_DEPTH_BITS;
    localparam int CNT_BITS = $clog2(`DC_MEM_LATENCY + 1);

    // Count value on which the access fires
    localparam logic [CNT_BITS-1:0] LAST_WAIT = CNT_BITS'(`DC_MEM_LATENCY - 1);

    dm_cache_pkg::word_t           mem [0:WORDS-1];
    logic [`DC_MEM_DEPTH_BITS-1:0] word_index;
    logic [CNT_BITS-1:0]           wait_cnt;

    assign word_index = maddr[`DC_MEM_DEPTH_BITS-1:0];  // Upper address bits alias

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // ############################################################
    // Wait states and access
    // ############################################################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wait_cnt <= '0;
            mready   <= 1'b0;
        end else if (!mvalid) begin
            wait_cnt <= '0;                             // Ready for the next request
            mready   <= 1'b0;
        end else if (mready) begin
            mready <= 1'b0;                             // One pulse per request
        end else if (wait_cnt == LAST_WAIT) begin
            // Stepping past LAST_WAIT keeps it from firing twice before mvalid drops
            wait_cnt <= wait_cnt + 1'b1;
            mready   <= 1'b1;
        end else if (wait_cnt < LAST_WAIT) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn && mvalid && !mready && wait_cnt == LAST_WAIT) begin
            if (|mwstrb) begin
                for (int b = 0; b < `DC_STRB_BITS; b++) begin
                    if (mwstrb[b]) begin
                        mem[word_index][8*b +: 8] <= mwdata[8*b +: 8];
                    end
                end
            end else begin
                mrdata <= mem[word_index];              // Valid while mready is high
            end
        end
    end

endmodule

// File: tb/cache_tb.sv
`timescale 1ns/1ps
`include "dm_cache_consts.svh"

module cache_tb;

    localparam int NUM_REQUESTS    = 215;               // 2 + 2 + 3 + 8 + 200 over all tests
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (4 * `DC_MEM_LATENCY + 10) + 100;
    localparam int LINES           = 1 << `DC_INDEX_BITS;
    localparam int WORDS           = 1 << `DC_MEM_DEPTH_BITS;

    logic                      clk;
    logic                      resetn;
    dm_cache_pkg::block_addr_t cblock_addr;
    dm_cache_pkg::word_t       cwdata;
    dm_cache_pkg::strb_t       cwstrb;
    logic                      cvalid;
    dm_cache_pkg::word_t       crdata;
    logic                      cready;

    dm_cache_pkg::word_t       ref_mem   [0:WORDS-1];   // Aliased like main_memory
    dm_cache_pkg::block_addr_t ref_tag   [0:LINES-1];   // Tag each line should hold
    logic                      ref_valid [0:LINES-1];

    string cur_test;
    int    checks;
    int    errors;
    int    tests;
    int    errors_at_start;

    cache_subsystem DUT (
        .clk         (clk),
        .resetn      (resetn),
        .cblock_addr (cblock_addr),
        .cwdata      (cwdata),
        .cwstrb      (cwstrb),
        .cvalid      (cvalid),
        .crdata      (crdata),
        .cready      (cready)
    );

    always #20 clk = ~clk;                              // 40 ns period

    // ############################################################
    // Handshake properties
    // ############################################################

    assert property (@(posedge clk) !resetn |=> !cready)
        else begin
            $display("cready was high in the cycle after a reset edge");
            errors++;
        end

    assert property (@(posedge clk) disable iff (!resetn) cready |-> $past(cvalid))
        else begin
            $display("cready was raised without a pending request");
            errors++;
        end

    assert property (@(posedge clk) disable iff (!resetn) cready |=> !cready)
        else begin
            $display("cready stayed high for more than one cycle");
            errors++;
        end

    // ############################################################
    // Reference model and checks
    // ############################################################

    function automatic dm_cache_pkg::word_t merge_bytes(input dm_cache_pkg::word_t old_word,
                                                        input dm_cache_pkg::word_t new_word,
                                                        input dm_cache_pkg::strb_t strb);
        dm_cache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < `DC_STRB_BITS; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];  // Only enabled lanes change
            end
        end
        return result;
    endfunction

    task automatic check_word(input string what, input dm_cache_pkg::word_t expected,
                              input dm_cache_pkg::word_t actual);
        checks++;
        assert (actual == expected)
            else begin
                $display("[ERROR] %s: %s expected %h, actual %h", cur_test, what,
                         expected, actual);
                errors++;
            end
    endtask

    task automatic check_latency(input logic expect_hit, input int cycles);
        checks++;
        if (expect_hit) begin
            assert (cycles == 2)
                else begin
                    $display("[ERROR] %s: hit latency expected 2, actual %0d", cur_test, cycles);
                    errors++;
                end
        end else begin
            assert (cycles > 2)
                else begin
                    $display("[ERROR] %s: miss latency expected above 2, actual %0d",
                             cur_test, cycles);
                    errors++;
                end
        end
    endtask

    // Drives one request on the requester port and checks it against the reference model
    task automatic issue_request(input dm_cache_pkg::block_addr_t addr,
                                 input dm_cache_pkg::word_t wdata,
                                 input dm_cache_pkg::strb_t strb);
        int                        idx;
        int                        slot;
        int                        cycles;
        logic                      expect_hit;
        dm_cache_pkg::block_addr_t tag;
        dm_cache_pkg::word_t       rdata;

        idx        = int'(addr[`DC_INDEX_BITS-1:0]);
        slot       = int'(addr[`DC_MEM_DEPTH_BITS-1:0]);
        tag        = addr >> `DC_INDEX_BITS;
        expect_hit = ref_valid[idx] && ref_tag[idx] == tag;

        @(negedge clk);
        cblock_addr = addr;
        cwdata      = wdata;
        cwstrb      = strb;
        cvalid      = 1'b1;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cready);
        rdata  = crdata;
        cvalid = 1'b0;                                  // The request ends once cready is seen

        if (strb == '0) begin
            check_word("read data", ref_mem[slot], rdata);
            check_latency(expect_hit, cycles);
        end else begin
            ref_mem[slot] = merge_bytes(ref_mem[slot], wdata, strb);
            if (&strb) begin
                check_word("write data", wdata, rdata);
            end else begin
                check_word("reread data", ref_mem[slot], rdata);
            end
        end
        // Reads, full writes and rereads all leave the line holding this word
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s finished with %0d errors", cur_test, errors - errors_at_start);
    endtask

    // ############################################################
    // Tests
    // ############################################################

    task automatic reset_test();
        begin_test("reset");
        repeat (4) @(negedge clk);                      // Idle with cvalid low
        issue_request(30'h05, '0, '0);
        issue_request(30'h2a, '0, '0);
        end_test();
    endtask

    task automatic full_write_test();
        begin_test("full_write");
        issue_request(30'h0c, 32'hcafe_f00d, 4'b1111);
        issue_request(30'h0c, '0, '0);                  // Should hit
        end_test();
    endtask

    task automatic partial_write_test();
        begin_test("partial_write");
        issue_request(30'h13, 32'h1122_3344, 4'b1111);
        issue_request(30'h13, 32'haabb_ccdd, 4'b0101);
        issue_request(30'h13, '0, '0);                  // Hit on the reread line
        end_test();
    endtask

    task automatic conflict_test();
        begin_test("conflict");
        issue_request(30'h21, 32'h0123_4567, 4'b1111);  // Index 1, tag 4
        issue_request(30'h29, 32'h89ab_cdef, 4'b1111);  // Index 1, tag 5
        for (int i = 0; i < 3; i++) begin
            issue_request(30'h21, '0, '0);
            issue_request(30'h29, '0, '0);
        end
        end_test();
    endtask

    task automatic random_test();
        dm_cache_pkg::block_addr_t addr;
        dm_cache_pkg::strb_t       strb;
        begin_test("random");
        for (int i = 0; i < 200; i++) begin
            addr = dm_cache_pkg::block_addr_t'($urandom_range(63, 0));
            if ($urandom_range(1, 0) == 0) begin
                strb = '0;
            end else begin
                strb = dm_cache_pkg::strb_t'($urandom_range(15, 1));
            end
            issue_request(addr, dm_cache_pkg::word_t'($urandom), strb);
        end
        end_test();
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        cblock_addr = '0;
        cwdata      = '0;
        cwstrb      = '0;
        cvalid      = 1'b0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        void'($urandom(32'h0b75218b));
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end

        repeat (8) @(negedge clk);
        resetn = 1'b1;

        reset_test();
        full_write_test();
        partial_write_test();
        conflict_test();
        random_test();

        @(negedge clk);
        $display("Tests: %0d  Checks: %0d  Errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule
